/* build.f */
rv_pkg.sv
pipe_if.sv
reg_file.sv
decode_stage.sv
id_ex.sv
execute_stage.sv
result_stage.sv
core_top.sv
core_tb.sv

/* core_patterns.txt */
// freeze nibble (1 = freeze for three cycles before the offer), then the instruction word
000500093 // addi x1, x0, 5
0ffd00113 // addi x2, x0, -3
0002081b3 // add x3, x1, x2
040208233 // sub x4, x1, x2
0800002b7 // lui x5, 0x80000
04042d313 // srai x6, x5, 4
00042d393 // srli x7, x5, 4
000112433 // slt x8, x2, x1
0001134b3 // sltu x9, x2, x1
07ff14513 // xori x10, x2, 0x7ff
0ff017593 // andi x11, x2, -16
00f00e613 // ori x12, x1, 0xf0
000309693 // slli x13, x1, 3
000109733 // sll x14, x1, x1
00012d7b3 // srl x15, x5, x1
04012d833 // sra x16, x5, x1
000b578b3 // and x17, x10, x11
00020e933 // or x18, x1, x2
00020c9b3 // xor x19, x1, x2
0fff12a13 // slti x20, x2, -1
0fff0ba93 // sltiu x21, x1, -1
012345b17 // auipc x22, 0x12345
000708013 // addi x0, x1, 7
101600bb3 // add x23, x0, x22
0001b8c13 // addi x24, x23, 1
1400c0cb3 // sub x25, x24, x0

/* core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module core_tb import rv_pkg::*; ();

    localparam int max_pats   = 64;
    localparam int n_random   = 40;
    localparam int wait_limit = 20;

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        instr_valid;
    logic        freeze;
    wire         hold;
    wire         wb_valid;
    wire  [4:0]  wb_rd;
    wire  [31:0] wb_data;
    wire  [31:0] wb_pc;

    logic [35:0] pats [max_pats];
    logic [31:0] model_regs [32];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    logic [31:0] exp_pc [$];
    logic [31:0] lcg_state;
    logic [31:0] next_pc;
    logic [4:0]  last_rd;
    bit          last_valid;
    bit          hold_due; // decode word depends on the op in id_ex
    bit          timed_out;
    int          mismatches;
    int          failures;
    int          accepted;
    int          retired;

    core_top dut (
        .clk(clk), .rst(rst), .instr(instr), .pc(pc), .instr_valid(instr_valid),
        .freeze(freeze), .hold(hold), .wb_valid(wb_valid), .wb_rd(wb_rd),
        .wb_data(wb_data), .wb_pc(wb_pc)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // RV32I integer semantics by funct3
    function automatic logic [31:0] alu_rule(input logic [2:0] f3, input bit alt,
                                             input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: if (alt) return a - b; else return a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: if (alt) return $signed(a) >>> b[4:0]; else return a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] model_result(input instr_u w, input logic [31:0] ipc);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] upper;
        a     = model_regs[w.i.rs1];
        b     = model_regs[w.r.rs2];
        imm   = {{20{w.i.imm12[11]}}, w.i.imm12};
        upper = {w.raw[31:12], 12'd0};
        case (w.r.opcode)
            op_rtype: return alu_rule(w.r.funct3, w.r.funct7[5], a, b);
            op_itype: return alu_rule(w.i.funct3, w.i.funct3 == 3'd5 && w.i.imm12[10], a, imm);
            op_lui:   return upper;
            default:  return ipc + upper; // auipc
        endcase
    endfunction

    function automatic bit depends_on(input instr_u w, input logic [4:0] rd);
        if (rd == 5'd0)
            return 1'b0;
        if (w.i.rs1 == rd)
            return 1'b1;
        return (w.r.opcode == op_rtype) && (w.r.rs2 == rd);
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic accept_model(input instr_u w);
        logic [31:0] res;
        res = model_result(w, next_pc);
        if (w.r.rd != 5'd0) begin
            model_regs[w.r.rd] = res;
            exp_rd.push_back(w.r.rd);
            exp_data.push_back(res);
            exp_pc.push_back(next_pc);
        end
        hold_due   = last_valid && depends_on(w, last_rd);
        last_rd    = w.r.rd;
        last_valid = 1'b1;
        accepted++;
        next_pc += 32'd4;
    endtask

    // counts the cycles that hold stays high, called just after an edge
    task automatic pass_hold(output int cycles);
        cycles = 0;
        while (hold && !timed_out) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > wait_limit) begin
                failures++;
                timed_out = 1'b1;
                $display("timeout: hold stayed high for %0d cycles", cycles);
            end
        end
    endtask

    task automatic offer(input logic [35:0] entry);
        int n;
        instr       = entry[31:0];
        pc          = next_pc;
        instr_valid = 1'b1;
        if (entry[32]) begin
            freeze = 1'b1;
            repeat (3) begin
                @(posedge clk);
                #1;
            end
            freeze = 1'b0;
        end
        pass_hold(n);
        check("hold cycles", n, hold_due);
        accept_model(entry[31:0]);
        @(posedge clk);
        #1;
    endtask

    task automatic make_random(output logic [31:0] word);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        bit          alt;
        lcg_state = lcg_next(lcg_state);
        r   = lcg_state;
        f3  = r[29:27];
        rd  = {2'b00, r[26:24]}; // x0..x7 keeps dependences frequent
        rs1 = {2'b00, r[23:21]};
        rs2 = {2'b00, r[20:18]};
        alt = r[17];
        imm = r[17:6];
        case (r[31:30])
            2'd0: word = {(alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                          rs2, rs1, f3, rd, op_rtype};
            2'd1: begin
                if (f3 == 3'd1)
                    imm = {7'h00, imm[4:0]};
                else if (f3 == 3'd5)
                    imm = {1'b0, alt, 5'd0, imm[4:0]};
                word = {imm, rs1, f3, rd, op_itype};
            end
            2'd2: word = {r[23:4], rd, op_lui};
            default: word = {r[23:4], rd, op_auipc};
        endcase
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (freeze)
                check("wb_valid under freeze", wb_valid, 32'd0);
            if (wb_valid) begin
                if (exp_rd.size() == 0) begin
                    failures++;
                    $display("unexpected retirement of x%0d at %0t ns", wb_rd, $time);
                end else begin
                    check("wb_rd", wb_rd, exp_rd.pop_front());
                    check("wb_data", wb_data, exp_data.pop_front());
                    check("wb_pc", wb_pc, exp_pc.pop_front());
                    retired++;
                end
            end
        end
    end

    initial begin
        int          n;
        int          waited;
        logic [31:0] word;
        clk         = 1'b0;
        rst         = 1'b1;
        instr       = nop_instr;
        pc          = '0;
        instr_valid = 1'b0;
        freeze      = 1'b0;
        lcg_state   = 32'h5b0b;
        next_pc     = '0;
        last_rd     = '0;
        last_valid  = 1'b0;
        hold_due    = 1'b0;
        timed_out   = 1'b0;
        mismatches  = 0;
        failures    = 0;
        accepted    = 0;
        retired     = 0;
        for (int k = 0; k < 32; k++)
            model_regs[k] = '0;
        $readmemh("core_patterns.txt", pats);

        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        check("hold after reset", hold, 32'd0);
        check("wb_valid after reset", wb_valid, 32'd0);

        for (int k = 0; k < max_pats && !$isunknown(pats[k]) && !timed_out; k++)
            offer(pats[k]);
        for (int k = 0; k < n_random && !timed_out; k++) begin
            make_random(word);
            offer({4'h0, word});
        end

        instr_valid = 1'b0;
        pass_hold(n);
        check("hold cycles at drain", n, hold_due);
        waited = 0;
        while (exp_rd.size() != 0 && !timed_out) begin
            @(posedge clk);
            waited++;
            if (waited > wait_limit) begin
                failures++;
                timed_out = 1'b1;
                $display("timeout: %0d expected retirements never appeared", exp_rd.size());
            end
        end
        if (!timed_out)
            repeat (6) @(posedge clk); // room for any stray retirement

        $display("mismatches %0d, other errors %0d, accepted %0d, retired %0d",
                 mismatches, failures, accepted, retired);
        if (mismatches == 0 && failures == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module core_top import rv_pkg::*; (
    input  wire                  clk,
    input  wire                  rst,
    input  wire [xlen_w-1:0]     instr,
    input  wire [xlen_w-1:0]     pc,
    input  wire                  instr_valid,
    input  wire                  freeze,
    output logic                 hold,
    output logic                 wb_valid,
    output logic [regaddr_w-1:0] wb_rd,
    output logic [xlen_w-1:0]    wb_data,
    output logic [xlen_w-1:0]    wb_pc
);

    logic [regaddr_w-1:0] raddr1;
    logic [regaddr_w-1:0] raddr2;
    logic [xlen_w-1:0]    rdata1;
    logic [xlen_w-1:0]    rdata2;
    logic [xlen_w-1:0]    arith_res;
    logic [xlen_w-1:0]    logic_res;
    logic [xlen_w-1:0]    shift_res;
    logic [xlen_w-1:0]    cmp_res;

    idex_if idex_d (.clk(clk));
    idex_if idex_q (.clk(clk));
    wb_if   wb_bus ();

    reg_file u_reg_file (
        .clk(clk), .rst(rst), .wb(wb_bus.dst),
        .raddr1(raddr1), .raddr2(raddr2), .rdata1(rdata1), .rdata2(rdata2)
    );

    decode_stage u_decode (
        .clk(clk), .rst(rst), .instr(instr), .pc(pc), .instr_valid(instr_valid),
        .freeze(freeze), .hold(hold), .raddr1(raddr1), .raddr2(raddr2),
        .rdata1(rdata1), .rdata2(rdata2), .prev_wd(idex_q.wd), .prev_wreg(idex_q.wreg),
        .idex(idex_d.dec)
    );

    id_ex u_id_ex (
        .clk(clk), .rst(rst), .hold(hold), .freeze(freeze),
        .d(idex_d.pipe), .q(idex_q.dec)
    );

    execute_stage u_execute (
        .op(idex_q.ex), .arith_res(arith_res), .logic_res(logic_res),
        .shift_res(shift_res), .cmp_res(cmp_res)
    );

    result_stage u_result (
        .clk(clk), .rst(rst), .freeze(freeze), .op(idex_q.ex),
        .arith_res(arith_res), .logic_res(logic_res), .shift_res(shift_res),
        .cmp_res(cmp_res), .wb(wb_bus.src), .wb_valid(wb_valid), .wb_rd(wb_rd),
        .wb_data(wb_data), .wb_pc(wb_pc)
    );

endmodule

`default_nettype wire

/* decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage import rv_pkg::*; (
    input  wire                  clk,
    input  wire                  rst,
    input  wire instr_u          instr,
    input  wire [xlen_w-1:0]     pc,
    input  wire                  instr_valid,
    input  wire                  freeze,
    output logic                 hold,
    output logic [regaddr_w-1:0] raddr1,
    output logic [regaddr_w-1:0] raddr2,
    input  wire [xlen_w-1:0]     rdata1,
    input  wire [xlen_w-1:0]     rdata2,
    input  wire [regaddr_w-1:0]  prev_wd,
    input  wire                  prev_wreg,
    idex_if.dec                  idex
);

    instr_u            instr_q;
    logic [xlen_w-1:0] pc_q;
    logic              valid_q;
    logic              is_rtype;
    logic              rs1_hit;
    logic              rs2_hit;

    // funct3 decode shared by R and I forms
    function automatic alu_op_t map_f3(input logic [2:0] f3, input logic sub, input logic sra);
        case (f3)
            f3_add_sub: map_f3 = sub ? alu_sub : alu_add;
            f3_sll:     map_f3 = alu_sll;
            f3_slt:     map_f3 = alu_slt;
            f3_sltu:    map_f3 = alu_sltu;
            f3_xor:     map_f3 = alu_xor;
            f3_srl_sra: map_f3 = sra ? alu_sra : alu_srl;
            f3_or:      map_f3 = alu_or;
            default:    map_f3 = alu_and;
        endcase
    endfunction

    function automatic res_sel_t class_of(input alu_op_t op);
        case (op)
            alu_add, alu_sub:          class_of = res_arith;
            alu_and, alu_or, alu_xor:  class_of = res_logic;
            alu_sll, alu_srl, alu_sra: class_of = res_shift;
            alu_slt, alu_sltu:         class_of = res_compare;
            default:                   class_of = res_nop;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            instr_q <= nop_instr;
            pc_q    <= '0;
            valid_q <= 1'b0;
        end else if (!freeze && !hold) begin
            valid_q <= instr_valid; // empty slot when nothing offered
            if (instr_valid) begin
                instr_q <= instr;
                pc_q    <= pc;
            end
        end
    end

    assign raddr1   = instr_q.i.rs1;
    assign raddr2   = instr_q.r.rs2;
    assign is_rtype = (instr_q.r.opcode == op_rtype);
    assign rs1_hit  = (instr_q.i.rs1 != '0) && (instr_q.i.rs1 == prev_wd);
    assign rs2_hit  = is_rtype && (instr_q.r.rs2 != '0) && (instr_q.r.rs2 == prev_wd);
    assign hold     = valid_q && prev_wreg && (rs1_hit || rs2_hit);

    always_comb begin
        idex.aluop   = alu_nop;
        idex.reg1    = rdata1;
        idex.reg2    = rdata2;
        idex.imm     = {{20{instr_q.i.imm12[11]}}, instr_q.i.imm12};
        idex.use_imm = 1'b0;
        idex.wd      = instr_q.r.rd;
        idex.wreg    = 1'b0;
        idex.pc      = pc_q;
        if (valid_q) begin
            case (instr_q.r.opcode)
                op_rtype: begin
                    idex.aluop = map_f3(instr_q.r.funct3, instr_q.r.funct7[5],
                                        instr_q.r.funct7[5]);
                    idex.wreg  = 1'b1;
                end
                op_itype: begin
                    idex.aluop   = map_f3(instr_q.i.funct3, 1'b0, instr_q.i.imm12[10]);
                    idex.use_imm = 1'b1;
                    idex.wreg    = 1'b1;
                    if (instr_q.i.funct3 == f3_sll || instr_q.i.funct3 == f3_srl_sra) begin
                        idex.imm = {27'd0, instr_q.i.imm12[4:0]}; // shamt
                    end
                end
                op_lui, op_auipc: begin
                    idex.aluop   = alu_add;
                    idex.imm     = {instr_q.raw[31:12], 12'd0};
                    idex.use_imm = 1'b1;
                    idex.wreg    = 1'b1;
                    idex.reg1    = (instr_q.r.opcode == op_auipc) ? pc_q : '0;
                end
                default: ; // unsupported, stays a nop
            endcase
        end
        idex.alusel = class_of(idex.aluop);
    end

    // one bubble clears a dependence
    a_hold_once: assert property (@(posedge clk) disable iff (rst)
        (hold && !freeze) |=> !hold);

endmodule

`default_nettype wire

/* execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage import rv_pkg::*; (
    idex_if.ex                op,
    output logic [xlen_w-1:0] arith_res,
    output logic [xlen_w-1:0] logic_res,
    output logic [xlen_w-1:0] shift_res,
    output logic [xlen_w-1:0] cmp_res
);

    logic [xlen_w-1:0] a;
    logic [xlen_w-1:0] b;
    logic [4:0]        shamt;

    assign a     = op.reg1;
    assign b     = op.use_imm ? op.imm : op.reg2;
    assign shamt = b[4:0];

    always_comb begin
        case (op.aluop)
            alu_add: arith_res = a + b;
            alu_sub: arith_res = a - b;
            default: arith_res = '0;
        endcase
    end

    always_comb begin
        case (op.aluop)
            alu_and: logic_res = a & b;
            alu_or:  logic_res = a | b;
            alu_xor: logic_res = a ^ b;
            default: logic_res = '0;
        endcase
    end

    always_comb begin
        case (op.aluop)
            alu_sll: shift_res = a << shamt;
            alu_srl: shift_res = a >> shamt;
            alu_sra: shift_res = $signed(a) >>> shamt; // sign fill
            default: shift_res = '0;
        endcase
    end

    always_comb begin
        cmp_res = '0;
        case (op.aluop)
            alu_slt:  cmp_res[0] = ($signed(a) < $signed(b));
            alu_sltu: cmp_res[0] = (a < b);
            default:  cmp_res[0] = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* id_ex.sv */
`timescale 1ns/1ps
`default_nettype none

module id_ex import rv_pkg::*; (
    input  wire  clk,
    input  wire  rst,
    input  wire  hold,
    input  wire  freeze,
    idex_if.pipe d,
    idex_if.dec  q
);

    // freeze wins over hold, bubble only when the pipe moves
    always_ff @(posedge clk) begin
        if (rst || (hold && !freeze)) begin
            q.aluop   <= alu_nop;
            q.alusel  <= res_nop;
            q.reg1    <= '0;
            q.reg2    <= '0;
            q.imm     <= '0;
            q.use_imm <= 1'b0;
            q.wd      <= '0;
            q.wreg    <= 1'b0;
            q.pc      <= '0;
        end else if (!freeze) begin
            q.aluop   <= d.aluop;
            q.alusel  <= d.alusel;
            q.reg1    <= d.reg1;
            q.reg2    <= d.reg2;
            q.imm     <= d.imm;
            q.use_imm <= d.use_imm;
            q.wd      <= d.wd;
            q.wreg    <= d.wreg;
            q.pc      <= d.pc;
        end
    end

    // the cycle after a hold carries a bubble
    a_bubble: assert property (@(posedge clk) disable iff (rst)
        (hold && !freeze) |=> (!q.wreg && q.alusel == res_nop && q.wd == '0));

endmodule

`default_nettype wire

/* pipe_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface idex_if import rv_pkg::*; (
    input wire clk
);

    alu_op_t              aluop;
    res_sel_t             alusel;
    logic [xlen_w-1:0]    reg1;
    logic [xlen_w-1:0]    reg2;
    logic [xlen_w-1:0]    imm;
    logic                 use_imm;
    logic [regaddr_w-1:0] wd;
    logic                 wreg;
    logic [xlen_w-1:0]    pc;

    modport dec  (output aluop, alusel, reg1, reg2, imm, use_imm, wd, wreg, pc);
    modport pipe (input  aluop, alusel, reg1, reg2, imm, use_imm, wd, wreg, pc);
    modport ex   (input  aluop, alusel, reg1, reg2, imm, use_imm, wd, wreg, pc);

    // a writing op always names a result class
    a_wreg_class: assert property (@(posedge clk) wreg |-> alusel != res_nop);

endinterface

interface wb_if import rv_pkg::*; ();

    logic                 we;
    logic [regaddr_w-1:0] waddr;
    logic [xlen_w-1:0]    wdata;

    modport src (output we, waddr, wdata);
    modport dst (input  we, waddr, wdata);

endinterface

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_pkg::*; (
    input  wire                  clk,
    input  wire                  rst,
    wb_if.dst                    wb,
    input  wire [regaddr_w-1:0]  raddr1,
    input  wire [regaddr_w-1:0]  raddr2,
    output logic [xlen_w-1:0]    rdata1,
    output logic [xlen_w-1:0]    rdata2
);

    logic [xlen_w-1:0] regs [2**regaddr_w];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < 2**regaddr_w; k++) begin
                regs[k] <= '0;
            end
        end else if (wb.we && wb.waddr != '0) begin // x0 stays zero
            regs[wb.waddr] <= wb.wdata;
        end
    end

    // same-cycle write shows through to the reader
    assign rdata1 = (raddr1 == '0) ? '0 :
                    (wb.we && wb.waddr == raddr1) ? wb.wdata : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 :
                    (wb.we && wb.waddr == raddr2) ? wb.wdata : regs[raddr2];

    // a write lands in the addressed register
    a_write_ok: assert property (@(posedge clk) disable iff (rst)
        (wb.we && wb.waddr != '0) |=> (regs[$past(wb.waddr)] == $past(wb.wdata)));

endmodule

`default_nettype wire

/* result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module result_stage import rv_pkg::*; (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  freeze,
    idex_if.ex                   op,
    input  wire [xlen_w-1:0]     arith_res,
    input  wire [xlen_w-1:0]     logic_res,
    input  wire [xlen_w-1:0]     shift_res,
    input  wire [xlen_w-1:0]     cmp_res,
    wb_if.src                    wb,
    output logic                 wb_valid,
    output logic [regaddr_w-1:0] wb_rd,
    output logic [xlen_w-1:0]    wb_data,
    output logic [xlen_w-1:0]    wb_pc
);

    logic [xlen_w-1:0]    sel_res;
    logic [xlen_w-1:0]    res_q;
    logic [xlen_w-1:0]    pc_q;
    logic [regaddr_w-1:0] rd_q;
    logic                 wreg_q;

    always_comb begin
        case (op.alusel)
            res_arith:   sel_res = arith_res;
            res_logic:   sel_res = logic_res;
            res_shift:   sel_res = shift_res;
            res_compare: sel_res = cmp_res;
            default:     sel_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wreg_q <= 1'b0;
            rd_q   <= '0;
        end else if (!freeze) begin
            wreg_q <= op.wreg;
            rd_q   <= op.wd;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            res_q <= sel_res;
            pc_q  <= op.pc;
        end
    end

    assign wb_valid = wreg_q && (rd_q != '0) && !freeze; // x0 results dropped
    assign wb_rd    = rd_q;
    assign wb_data  = res_q;
    assign wb_pc    = pc_q;

    assign wb.we    = wb_valid;
    assign wb.waddr = rd_q;
    assign wb.wdata = res_q;

    // a retiring result is fully known
    a_data_known: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> !$isunknown({wb_data, wb_pc}));

    // retirement slot is parked while frozen
    a_freeze_stable: assert property (@(posedge clk) disable iff (rst)
        freeze |=> ($stable(wb_rd) && $stable(wb_pc) && $stable(wb_data)));

endmodule

`default_nettype wire

/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int xlen_w    = 32;
    localparam int regaddr_w = 5;

    // major opcodes, bits [6:0]
    localparam logic [6:0] op_rtype = 7'b0110011;
    localparam logic [6:0] op_itype = 7'b0010011;
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9,
        alu_nop  = 4'd10
    } alu_op_t;

    typedef enum logic [2:0] {
        res_arith   = 3'd0,
        res_logic   = 3'd1,
        res_shift   = 3'd2,
        res_compare = 3'd3,
        res_nop     = 3'd4
    } res_sel_t;

    typedef struct packed {
        logic [6:0]           funct7;
        logic [regaddr_w-1:0] rs2;
        logic [regaddr_w-1:0] rs1;
        logic [2:0]           funct3;
        logic [regaddr_w-1:0] rd;
        logic [6:0]           opcode;
    } rtype_t;

    typedef struct packed {
        logic [11:0]          imm12;
        logic [regaddr_w-1:0] rs1;
        logic [2:0]           funct3;
        logic [regaddr_w-1:0] rd;
        logic [6:0]           opcode;
    } itype_t;

    typedef union packed {
        logic [xlen_w-1:0] raw;
        rtype_t            r;
        itype_t            i;
    } instr_u;

    localparam logic [xlen_w-1:0] nop_instr = 32'h0000_0013; // addi x0,x0,0

endpackage

`default_nettype wire
